// ==== rtl/bus_decode.sv ====
`timescale 1ns/100ps

module bus_decode (
        input  logic                clk_dot4x,
        input  logic                rst,
        input  logic                ce,
        input  logic                rw,
        input  logic                dav,
        input  vic_pkg::reg_addr_t  adi,
        input  vic_pkg::bus_data_t  dbi,
        output vic_pkg::bus_req_t   req
);

        // strobes are qualified here so later stages only see rd and wr
        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        req.rd <= 1'b0;
                        req.wr <= 1'b0;
                end else begin
                        req.rd <= !ce && rw;
                        req.wr <= !ce && !rw && dav;
                end
        end

        // address and data travel alongside the strobes
        always_ff @(posedge clk_dot4x) begin
                req.addr <= adi;
                req.data <= dbi;
        end

endmodule

// ==== rtl/color_regs.sv ====
`timescale 1ns/100ps

module color_regs (
        input  logic                 clk_dot4x,
        input  logic                 rst,
        input  vic_pkg::bus_req_t    req,
        output vic_pkg::color_regs_t colors,
        output vic_pkg::bank_reply_t reply
);

        vic_pkg::reg_addr_t off;
        logic               in_range;
        vic_pkg::color_t    sel;

        // seven consecutive registers starting at the border color
        assign off      = req.addr - vic_pkg::reg_border_color;
        assign in_range = (req.addr >= vic_pkg::reg_border_color) && (off < 6'd7);

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        colors <= '0;
                end else if (req.wr && in_range) begin
                        case (off[2:0])
                                3'd0: colors.ec  <= req.data[3:0];
                                3'd1: colors.b0c <= req.data[3:0];
                                3'd2: colors.b1c <= req.data[3:0];
                                3'd3: colors.b2c <= req.data[3:0];
                                3'd4: colors.b3c <= req.data[3:0];
                                3'd5: colors.mc0 <= req.data[3:0];
                                default: colors.mc1 <= req.data[3:0];
                        endcase
                end
        end

        always_comb begin
                case (off[2:0])
                        3'd0: sel = colors.ec;
                        3'd1: sel = colors.b0c;
                        3'd2: sel = colors.b1c;
                        3'd3: sel = colors.b2c;
                        3'd4: sel = colors.b3c;
                        3'd5: sel = colors.mc0;
                        default: sel = colors.mc1;
                endcase
        end

        // upper nibble is not stored and reads as ones
        assign reply.hit  = req.rd && in_range;
        assign reply.data = {4'hf, sel};

endmodule

// ==== rtl/read_mux.sv ====
`timescale 1ns/100ps

module read_mux (
        input  logic                 clk_dot4x,
        input  logic                 rst,
        input  logic                 rd,
        input  vic_pkg::bank_reply_t sprite_reply,
        input  vic_pkg::bank_reply_t screen_reply,
        input  vic_pkg::bank_reply_t color_reply,
        output vic_pkg::bus_data_t   dbo
);

        vic_pkg::bus_data_t rd_data;

        // banks decode disjoint ranges so at most one hit is set
        always_comb begin
                if (sprite_reply.hit)
                        rd_data = sprite_reply.data;
                else if (screen_reply.hit)
                        rd_data = screen_reply.data;
                else if (color_reply.hit)
                        rd_data = color_reply.data;
                else
                        rd_data = vic_pkg::unmapped_read;
        end

        // dbo keeps the last read byte until the next read
        always_ff @(posedge clk_dot4x) begin
                if (rst)
                        dbo <= '0;
                else if (rd)
                        dbo <= rd_data;
        end

endmodule

// ==== rtl/screen_regs.sv ====
`timescale 1ns/100ps

module screen_regs (
        input  logic                  clk_dot4x,
        input  logic                  rst,
        input  vic_pkg::bus_req_t     req,
        input  vic_pkg::raster_t      raster_line,
        output vic_pkg::screen_ctrl_t screen,
        output vic_pkg::bank_reply_t  reply
);

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        // display on, vertical scroll centred
                        screen <= '{den: 1'b1, yscroll: vic_pkg::yscroll_reset, default: '0};
                end else if (req.wr) begin
                        case (req.addr)
                                vic_pkg::reg_screen_ctrl1: begin
                                        screen.yscroll       <= req.data[2:0];
                                        screen.rsel          <= req.data[3];
                                        screen.den           <= req.data[4];
                                        screen.bmm           <= req.data[5];
                                        screen.ecm           <= req.data[6];
                                        screen.raster_cmp[8] <= req.data[7];
                                end
                                vic_pkg::reg_raster: screen.raster_cmp[7:0] <= req.data;
                                vic_pkg::reg_screen_ctrl2: begin
                                        screen.xscroll <= req.data[2:0];
                                        screen.csel    <= req.data[3];
                                        screen.mcm     <= req.data[4];
                                        screen.res     <= req.data[5];
                                end
                                vic_pkg::reg_memory_setup: begin
                                        screen.cb <= req.data[3:1];
                                        screen.vm <= req.data[7:4];
                                end
                                default: ;
                        endcase
                end
        end

        // raster reads return the live line, not the compare value
        always_comb begin
                reply.hit  = req.rd;
                reply.data = vic_pkg::unmapped_read;
                case (req.addr)
                        vic_pkg::reg_screen_ctrl1:
                                reply.data = {raster_line[8], screen.ecm, screen.bmm,
                                              screen.den, screen.rsel, screen.yscroll};
                        vic_pkg::reg_raster:
                                reply.data = raster_line[7:0];
                        vic_pkg::reg_screen_ctrl2:
                                reply.data = {2'b11, screen.res, screen.mcm, screen.csel,
                                              screen.xscroll};
                        vic_pkg::reg_memory_setup:
                                reply.data = {screen.vm, screen.cb, 1'b1};
                        default: reply.hit = 1'b0;
                endcase
        end

endmodule

// ==== rtl/sprite_regs.sv ====
`timescale 1ns/100ps

module sprite_regs (
        input  logic                  clk_dot4x,
        input  logic                  rst,
        input  vic_pkg::bus_req_t     req,
        output vic_pkg::sprite_ctrl_t sprite_ctrl,
        output vic_pkg::sprite_pos_t  [vic_pkg::num_sprites-1:0] sprite_pos,
        output vic_pkg::color_t       [vic_pkg::num_sprites-1:0] sprite_col,
        output vic_pkg::bank_reply_t  reply
);

        vic_pkg::reg_addr_t     pos_off;
        vic_pkg::reg_addr_t     col_off;
        logic                   pos_hit;
        logic                   col_hit;
        logic                   sel_y;
        logic [2:0]             pos_idx;
        logic [2:0]             col_idx;
        vic_pkg::sprite_mask_t  x_msb;

        assign pos_off = req.addr - vic_pkg::reg_sprite_x0;
        assign col_off = req.addr - vic_pkg::reg_sprite_color0;
        assign pos_hit = pos_off < vic_pkg::reg_addr_t'(2 * vic_pkg::num_sprites);
        assign col_hit = (req.addr >= vic_pkg::reg_sprite_color0) &&
                         (col_off < vic_pkg::reg_addr_t'(vic_pkg::num_sprites));
        // even offsets are x, odd offsets are y
        assign sel_y   = pos_off[0] == vic_pkg::reg_sprite_y0[0];
        assign pos_idx = pos_off[3:1];
        assign col_idx = col_off[2:0];

        // gather bit 8 of every x position into one byte
        always_comb begin
                for (int i = 0; i < vic_pkg::num_sprites; i++) begin
                        x_msb[i] = sprite_pos[i].x[8];
                end
        end

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        sprite_ctrl <= '0;
                        sprite_pos  <= '0;
                        sprite_col  <= '0;
                end else if (req.wr) begin
                        if (pos_hit) begin
                                if (sel_y)
                                        sprite_pos[pos_idx].y <= req.data;
                                else
                                        sprite_pos[pos_idx].x[7:0] <= req.data;
                        end else if (col_hit) begin
                                sprite_col[col_idx] <= req.data[3:0];
                        end else begin
                                case (req.addr)
                                        vic_pkg::reg_sprite_x_msb: begin
                                                // scatter one bit into each sprite
                                                for (int i = 0; i < vic_pkg::num_sprites; i++) begin
                                                        sprite_pos[i].x[8] <= req.data[i];
                                                end
                                        end
                                        vic_pkg::reg_sprite_enable:   sprite_ctrl.en  <= req.data;
                                        vic_pkg::reg_sprite_expand_y: sprite_ctrl.ye  <= req.data;
                                        vic_pkg::reg_sprite_priority: sprite_ctrl.pri <= req.data;
                                        vic_pkg::reg_sprite_mc_mode:  sprite_ctrl.mmc <= req.data;
                                        vic_pkg::reg_sprite_expand_x: sprite_ctrl.xe  <= req.data;
                                        default: ;
                                endcase
                        end
                end
        end

        always_comb begin
                reply.hit  = 1'b0;
                reply.data = vic_pkg::unmapped_read;
                if (req.rd) begin
                        reply.hit = 1'b1;
                        if (pos_hit) begin
                                if (sel_y)
                                        reply.data = sprite_pos[pos_idx].y;
                                else
                                        reply.data = sprite_pos[pos_idx].x[7:0];
                        end else if (col_hit) begin
                                reply.data = {4'hf, sprite_col[col_idx]};
                        end else begin
                                case (req.addr)
                                        vic_pkg::reg_sprite_x_msb:    reply.data = x_msb;
                                        vic_pkg::reg_sprite_enable:   reply.data = sprite_ctrl.en;
                                        vic_pkg::reg_sprite_expand_y: reply.data = sprite_ctrl.ye;
                                        vic_pkg::reg_sprite_priority: reply.data = sprite_ctrl.pri;
                                        vic_pkg::reg_sprite_mc_mode:  reply.data = sprite_ctrl.mmc;
                                        vic_pkg::reg_sprite_expand_x: reply.data = sprite_ctrl.xe;
                                        default: reply.hit = 1'b0;
                                endcase
                        end
                end
        end

endmodule

// ==== rtl/vic_pkg.sv ====
package vic_pkg;

        localparam int num_sprites = 8;

        typedef logic [5:0] reg_addr_t;
        typedef logic [7:0] bus_data_t;
        typedef logic [3:0] color_t;
        typedef logic [8:0] raster_t;
        typedef logic [8:0] sprite_x_t;
        typedef logic [7:0] sprite_mask_t;

        // sprite positions interleave x and y from 0x00 to 0x0f
        localparam reg_addr_t reg_sprite_x0       = 6'h00;
        localparam reg_addr_t reg_sprite_y0       = 6'h01;
        localparam reg_addr_t reg_sprite_x_msb    = 6'h10;
        localparam reg_addr_t reg_screen_ctrl1    = 6'h11;
        localparam reg_addr_t reg_raster          = 6'h12;
        localparam reg_addr_t reg_sprite_enable   = 6'h15;
        localparam reg_addr_t reg_screen_ctrl2    = 6'h16;
        localparam reg_addr_t reg_sprite_expand_y = 6'h17;
        localparam reg_addr_t reg_memory_setup    = 6'h18;
        localparam reg_addr_t reg_sprite_priority = 6'h1b;
        localparam reg_addr_t reg_sprite_mc_mode  = 6'h1c;
        localparam reg_addr_t reg_sprite_expand_x = 6'h1d;
        // border, four backgrounds and two multicolors follow in order
        localparam reg_addr_t reg_border_color    = 6'h20;
        localparam reg_addr_t reg_sprite_color0   = 6'h27;

        localparam bus_data_t unmapped_read = 8'hff;
        localparam logic [2:0] yscroll_reset = 3'd3;

        typedef struct packed {
                logic      rd;
                logic      wr;
                reg_addr_t addr;
                bus_data_t data;
        } bus_req_t;

        typedef struct packed {
                logic      hit;
                bus_data_t data;
        } bank_reply_t;

        typedef struct packed {
                logic [2:0] xscroll;
                logic [2:0] yscroll;
                logic       csel;
                logic       rsel;
                logic       den;
                logic       bmm;
                logic       ecm;
                logic       res;
                logic       mcm;
                raster_t    raster_cmp;
                logic [2:0] cb;
                logic [3:0] vm;
        } screen_ctrl_t;

        typedef struct packed {
                sprite_mask_t en;
                sprite_mask_t xe;
                sprite_mask_t ye;
                sprite_mask_t pri;
                sprite_mask_t mmc;
        } sprite_ctrl_t;

        typedef struct packed {
                sprite_x_t  x;
                logic [7:0] y;
        } sprite_pos_t;

        typedef struct packed {
                color_t ec;
                color_t b0c;
                color_t b1c;
                color_t b2c;
                color_t b3c;
                color_t mc0;
                color_t mc1;
        } color_regs_t;

endpackage

// ==== rtl/vic_registers.sv ====
`timescale 1ns/100ps

module vic_registers (
        input  logic                  clk_dot4x,
        input  logic                  rst,
        input  logic                  ce,
        input  logic                  rw,
        input  logic                  dav,
        input  vic_pkg::reg_addr_t    adi,
        input  vic_pkg::bus_data_t    dbi,
        input  vic_pkg::raster_t      raster_line,
        output vic_pkg::bus_data_t    dbo,
        output vic_pkg::screen_ctrl_t screen,
        output vic_pkg::sprite_ctrl_t sprite_ctrl,
        output vic_pkg::sprite_pos_t  [vic_pkg::num_sprites-1:0] sprite_pos,
        output vic_pkg::color_t       [vic_pkg::num_sprites-1:0] sprite_col,
        output vic_pkg::color_regs_t  colors
);

        vic_pkg::bus_req_t    req;
        vic_pkg::bank_reply_t sprite_reply;
        vic_pkg::bank_reply_t screen_reply;
        vic_pkg::bank_reply_t color_reply;

        bus_decode u_bus_decode (
                .clk_dot4x (clk_dot4x),
                .rst       (rst),
                .ce        (ce),
                .rw        (rw),
                .dav       (dav),
                .adi       (adi),
                .dbi       (dbi),
                .req       (req)
        );

        sprite_regs u_sprite_regs (
                .clk_dot4x   (clk_dot4x),
                .rst         (rst),
                .req         (req),
                .sprite_ctrl (sprite_ctrl),
                .sprite_pos  (sprite_pos),
                .sprite_col  (sprite_col),
                .reply       (sprite_reply)
        );

        screen_regs u_screen_regs (
                .clk_dot4x   (clk_dot4x),
                .rst         (rst),
                .req         (req),
                .raster_line (raster_line),
                .screen      (screen),
                .reply       (screen_reply)
        );

        color_regs u_color_regs (
                .clk_dot4x (clk_dot4x),
                .rst       (rst),
                .req       (req),
                .colors    (colors),
                .reply     (color_reply)
        );

        read_mux u_read_mux (
                .clk_dot4x    (clk_dot4x),
                .rst          (rst),
                .rd           (req.rd),
                .sprite_reply (sprite_reply),
                .screen_reply (screen_reply),
                .color_reply  (color_reply),
                .dbo          (dbo)
        );

endmodule

// ==== verification/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

task automatic load_vectors();
        // columns are write flag, address, data, raster line, expected read byte
        vectors.push_back(make_row(1'b0, 6'h11, 8'h00, 9'h000, 8'h13));
        vectors.push_back(make_row(1'b0, 6'h16, 8'h00, 9'h000, 8'hc0));
        vectors.push_back(make_row(1'b0, 6'h18, 8'h00, 9'h000, 8'h01));
        vectors.push_back(make_row(1'b0, 6'h20, 8'h00, 9'h000, 8'hf0));
        // sprite positions and the shared bit 8
        vectors.push_back(make_row(1'b1, 6'h00, 8'ha5, 9'h000, 8'h00));
        vectors.push_back(make_row(1'b1, 6'h01, 8'h3c, 9'h000, 8'h00));
        vectors.push_back(make_row(1'b1, 6'h0f, 8'he1, 9'h000, 8'h00));
        vectors.push_back(make_row(1'b1, 6'h10, 8'h81, 9'h000, 8'h00));
        vectors.push_back(make_row(1'b0, 6'h00, 8'h00, 9'h000, 8'ha5));
        vectors.push_back(make_row(1'b0, 6'h0f, 8'h00, 9'h000, 8'he1));
        vectors.push_back(make_row(1'b0, 6'h10, 8'h00, 9'h000, 8'h81));
        vectors.push_back(make_row(1'b1, 6'h15, 8'h0f, 9'h000, 8'h00));
        vectors.push_back(make_row(1'b0, 6'h15, 8'h00, 9'h000, 8'h0f));
        // screen control, raster compare and memory setup
        vectors.push_back(make_row(1'b1, 6'h11, 8'h9b, 9'h000, 8'h00));
        vectors.push_back(make_row(1'b0, 6'h11, 8'h00, 9'h000, 8'h1b));
        vectors.push_back(make_row(1'b1, 6'h12, 8'h42, 9'h000, 8'h00));
        vectors.push_back(make_row(1'b0, 6'h12, 8'h00, 9'h1c3, 8'hc3));
        vectors.push_back(make_row(1'b0, 6'h11, 8'h00, 9'h1c3, 8'h9b));
        vectors.push_back(make_row(1'b1, 6'h16, 8'h15, 9'h1c3, 8'h00));
        vectors.push_back(make_row(1'b0, 6'h16, 8'h00, 9'h1c3, 8'hd5));
        vectors.push_back(make_row(1'b1, 6'h18, 8'h3e, 9'h1c3, 8'h00));
        vectors.push_back(make_row(1'b0, 6'h18, 8'h00, 9'h1c3, 8'h3f));
        // colors keep the low nibble only
        vectors.push_back(make_row(1'b1, 6'h20, 8'ha7, 9'h000, 8'h00));
        vectors.push_back(make_row(1'b0, 6'h20, 8'h00, 9'h000, 8'hf7));
        vectors.push_back(make_row(1'b1, 6'h2e, 8'h0e, 9'h000, 8'h00));
        vectors.push_back(make_row(1'b0, 6'h2e, 8'h00, 9'h000, 8'hfe));
        // dropped and unmapped addresses
        vectors.push_back(make_row(1'b1, 6'h13, 8'h55, 9'h000, 8'h00));
        vectors.push_back(make_row(1'b1, 6'h1f, 8'h55, 9'h000, 8'h00));
        vectors.push_back(make_row(1'b1, 6'h3f, 8'h55, 9'h000, 8'h00));
        vectors.push_back(make_row(1'b0, 6'h13, 8'h00, 9'h000, 8'hff));
        vectors.push_back(make_row(1'b0, 6'h1a, 8'h00, 9'h000, 8'hff));
        vectors.push_back(make_row(1'b0, 6'h2f, 8'h00, 9'h000, 8'hff));
        vectors.push_back(make_row(1'b0, 6'h3f, 8'h00, 9'h000, 8'hff));
endtask

`endif

// ==== verification/tb_vic_registers.sv ====
`timescale 1ns/100ps

module tb_vic_registers;

        typedef struct packed {
                logic       wr;
                logic [5:0] addr;
                logic [7:0] data;
                logic [8:0] raster;
                logic [7:0] exp;
        } vec_t;

        logic                  clk_dot4x;
        logic                  rst;
        logic                  ce;
        logic                  rw;
        logic                  dav;
        vic_pkg::reg_addr_t    adi;
        vic_pkg::bus_data_t    dbi;
        vic_pkg::raster_t      raster_line;
        vic_pkg::bus_data_t    dbo;
        vic_pkg::screen_ctrl_t screen;
        vic_pkg::sprite_ctrl_t sprite_ctrl;
        vic_pkg::sprite_pos_t  [vic_pkg::num_sprites-1:0] sprite_pos;
        vic_pkg::color_t       [vic_pkg::num_sprites-1:0] sprite_col;
        vic_pkg::color_regs_t  colors;

        vec_t        vectors [$];
        // reference model holds one written byte per address
        logic [7:0]  regs [64];
        // pending read checks where bit 8 marks a read
        logic [8:0]  pend [3];
        // last byte read back, held on dbo between reads
        logic [7:0]  dbo_exp;
        logic [31:0] seed;

        vic_registers dut (.*);

        always #50 clk_dot4x = ~clk_dot4x;

        function automatic vec_t make_row(logic wr, logic [5:0] addr, logic [7:0] data,
                                          logic [8:0] raster, logic [7:0] exp);
                make_row = {wr, addr, data, raster, exp};
        endfunction

        `include "tb_vectors.svh"

        function automatic logic [31:0] next_random(logic [31:0] s);
                s = s ^ (s << 13);
                s = s ^ (s >> 17);
                s = s ^ (s << 5);
                return s;
        endfunction

        // read rules of the register map applied to the model bytes
        function automatic logic [7:0] expected_read(logic [5:0] addr, logic [8:0] line);
                case (addr)
                        6'h11: return {line[8], regs[addr][6:0]};
                        6'h12: return line[7:0];
                        6'h16: return {2'b11, regs[addr][5:0]};
                        6'h18: return {regs[addr][7:1], 1'b1};
                        6'h10, 6'h15, 6'h17, 6'h1b, 6'h1c, 6'h1d: return regs[addr];
                        default: ;
                endcase
                if (addr < 6'h10)
                        return regs[addr];
                if (addr >= 6'h20 && addr <= 6'h2e)
                        return {4'hf, regs[addr][3:0]};
                return 8'hff;
        endfunction

        task automatic check(string name, logic [63:0] got, logic [63:0] exp);
                if (got !== exp) begin
                        $display("MISMATCH %s got %h expected %h", name, got, exp);
                        $display("TEST FAIL");
                        $fatal(1, "stopping at the first error");
                end
        endtask

        // output structs rebuilt from the model bytes
        task automatic check_outputs();
                for (int i = 0; i < vic_pkg::num_sprites; i++) begin
                        check($sformatf("sprite_pos[%0d]", i), sprite_pos[i],
                              {regs['h10][i], regs[2*i], regs[2*i+1]});
                        check($sformatf("sprite_col[%0d]", i), sprite_col[i],
                              regs['h27+i][3:0]);
                end
                check("sprite_ctrl", sprite_ctrl,
                      {regs['h15], regs['h1d], regs['h17], regs['h1b], regs['h1c]});
                check("screen", screen,
                      {regs['h16][2:0], regs['h11][2:0], regs['h16][3], regs['h11][3],
                       regs['h11][4], regs['h11][5], regs['h11][6], regs['h16][5],
                       regs['h16][4], regs['h11][7], regs['h12], regs['h18][3:1],
                       regs['h18][7:4]});
                check("colors", colors,
                      {regs['h20][3:0], regs['h21][3:0], regs['h22][3:0], regs['h23][3:0],
                       regs['h24][3:0], regs['h25][3:0], regs['h26][3:0]});
        endtask

        // drives one bus cycle and checks dbo against the read issued two edges earlier
        task automatic bus_cycle(logic active, logic wr, logic [5:0] addr, logic [7:0] data,
                                 logic [8:0] line, logic [8:0] exp_rd);
                @(posedge clk_dot4x);
                ce          <= !active;
                rw          <= !wr;
                dav         <= wr;
                adi         <= addr;
                dbi         <= data;
                raster_line <= line;
                if (active && wr)
                        regs[addr] = data;
                pend[2] = pend[1];
                pend[1] = pend[0];
                pend[0] = active ? exp_rd : 9'h000;
                @(negedge clk_dot4x);
                if (pend[2][8])
                        dbo_exp = pend[2][7:0];
                check("dbo", dbo, dbo_exp);
        endtask

        initial begin
                int wait_cnt;
                clk_dot4x   = 1'b0;
                rst         = 1'b1;
                ce          = 1'b1;
                rw          = 1'b1;
                dav         = 1'b0;
                adi         = '0;
                dbi         = '0;
                raster_line = '0;
                seed        = 32'h78c80d81;
                dbo_exp     = 8'h00;
                foreach (pend[i])
                        pend[i] = 9'h000;
                foreach (regs[a])
                        regs[a] = 8'h00;
                // reset values have den set and yscroll at 3
                regs['h11] = 8'h13;
                load_vectors();
                repeat (4) @(posedge clk_dot4x);
                rst <= 1'b0;
                wait_cnt = 0;
                while (rst !== 1'b0 || dbo !== 8'h00 || screen.yscroll !== 3'd3) begin
                        @(negedge clk_dot4x);
                        wait_cnt++;
                        if (wait_cnt > 10) begin
                                $display("TEST FAIL");
                                $fatal(1, "timeout waiting for the DUT to leave reset");
                        end
                end
                check_outputs();
                // directed rows with the pipeline drained after each one
                foreach (vectors[i]) begin
                        bus_cycle(1'b1, vectors[i].wr, vectors[i].addr, vectors[i].data,
                                  vectors[i].raster, {!vectors[i].wr, vectors[i].exp});
                        bus_cycle(1'b0, 1'b0, 6'h00, 8'h00, vectors[i].raster, 9'h000);
                        bus_cycle(1'b0, 1'b0, 6'h00, 8'h00, vectors[i].raster, 9'h000);
                        check_outputs();
                end
                // back to back random traffic against the model
                for (int n = 0; n < 200; n++) begin
                        seed = next_random(seed);
                        bus_cycle(1'b1, seed[8], seed[5:0], seed[23:16], 9'h0a7,
                                  {!seed[8], expected_read(seed[5:0], 9'h0a7)});
                end
                bus_cycle(1'b0, 1'b0, 6'h00, 8'h00, 9'h0a7, 9'h000);
                bus_cycle(1'b0, 1'b0, 6'h00, 8'h00, 9'h0a7, 9'h000);
                check_outputs();
                $display("TEST PASS");
                $finish;
        end

endmodule

// ==== vlog.f ====
+incdir+verification
rtl/vic_pkg.sv
rtl/bus_decode.sv
rtl/sprite_regs.sv
rtl/screen_regs.sv
rtl/color_regs.sv
rtl/read_mux.sv
rtl/vic_registers.sv
verification/tb_vic_registers.sv
